// File: list.f
hdl/panel_pkg.sv
hdl/command_decoder.sv
hdl/cmd_fill_panel.sv
hdl/fill_area_engine.sv
hdl/frame_buffer.sv
hdl/panel_cmd_top.sv
verif/tb_panel_cmd.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_panel_cmd \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_panel_cmd > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: verif/tb_panel_cmd.sv
`timescale 1ns/1ns

module tb_panel_cmd;

    localparam int PIXEL_WIDTH     = 16;
    localparam int PIXEL_HEIGHT    = 8;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int COLOR_W         = BYTES_PER_PIXEL * 8;
    localparam int COLUMNS         = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int PANEL_BYTES     = PIXEL_HEIGHT * COLUMNS;
    localparam int NUM_FILLS       = 3;
    localparam int MARGIN_CYCLES   = NUM_FILLS * (PANEL_BYTES + 20) + 500;    // Readback and gaps
    localparam int TIMEOUT_CYCLES  = NUM_FILLS * (PANEL_BYTES + 20) + MARGIN_CYCLES;
    localparam logic [31:0] RANDOM_SEED = 32'he058_b456;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    panel_pkg::byte_t   data_in;
    logic               data_valid;
    panel_pkg::row_t    read_row;
    panel_pkg::column_t read_column;
    logic               ready;
    logic               done;
    panel_pkg::byte_t   read_data;

    logic               last_color_strobe = 1'b0;
    logic               fill_pending = 1'b0;    // A complete fill command is in flight
    int                 done_count = 0;
    logic [COLOR_W-1:0] color_a, color_b, color_c;
    panel_pkg::byte_t   pixel_bytes[$];         // Colour bytes in the order they were sent

    always #2 clk = ~clk;

    panel_cmd_top #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .read_row    (read_row),
        .read_column (read_column),
        .ready       (ready),
        .done        (done),
        .read_data   (read_data)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    always @(negedge clk) begin
        if (!reset && done) begin
            done_count <= done_count + 1;
        end
    end

    a_reset_values: assert property (@(posedge clk) $fell(reset) |-> ready && !done)
        else fail_run($sformatf(
            "CHECK FAILED ready/done after reset: got 0x%0h/0x%0h expected 0x1/0x0",
            $sampled(ready), $sampled(done)));
    a_last_byte_accepted: assert property (
        @(posedge clk) disable iff (reset) last_color_strobe |-> ready)
        else fail_run("CHECK FAILED ready at last colour byte: got 0x0 expected 0x1");
    a_ready_drops: assert property (
        @(posedge clk) disable iff (reset) last_color_strobe |=> !ready)
        else fail_run("CHECK FAILED ready after last colour byte: got 0x1 expected 0x0");
    a_ready_low_until_done: assert property (
        @(posedge clk) disable iff (reset) (!ready && !done) |=> !ready)
        else fail_run("CHECK FAILED ready before done: got 0x1 expected 0x0");
    a_ready_low_at_done: assert property (@(posedge clk) disable iff (reset) done |-> !ready)
        else fail_run("CHECK FAILED ready during done: got 0x1 expected 0x0");
    a_single_done: assert property (@(posedge clk) disable iff (reset) done |=> ready && !done)
        else fail_run($sformatf(
            "CHECK FAILED ready/done after done: got 0x%0h/0x%0h expected 0x1/0x0",
            $sampled(ready), $sampled(done)));
    a_ready_rises_after_done: assert property (
        @(posedge clk) disable iff (reset) $rose(ready) |-> $past(done))
        else fail_run("CHECK FAILED ready rose without done: got done 0x0 expected 0x1");
    a_done_only_for_fill: assert property (
        @(posedge clk) disable iff (reset) done |-> fill_pending)
        else fail_run("CHECK FAILED done without a fill command: got 0x1 expected 0x0");

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("Run timed out after %0d cycles before all tests finished",
            TIMEOUT_CYCLES));
    end

    function automatic logic [COLOR_W-1:0] random_color();
        logic [31:0] rnd;
        rnd = $urandom();
        return rnd[COLOR_W-1:0];
    endfunction

    task automatic send_byte(input panel_pkg::byte_t value, input logic last);
        @(negedge clk);
        data_in           = value;
        data_valid        = 1'b1;
        last_color_strobe = last;
        if (last) begin
            fill_pending = 1'b1;
        end
        @(negedge clk);
        data_valid        = 1'b0;
        last_color_strobe = 1'b0;
    endtask

    // Opcode, then colour bytes MSB first
    task automatic start_fill(input logic [COLOR_W-1:0] color);
        pixel_bytes.delete();
        send_byte(panel_pkg::OP_FILL_PANEL, 1'b0);
        for (int i = BYTES_PER_PIXEL - 1; i >= 0; i--) begin
            pixel_bytes.push_back(color[i*8 +: 8]);
            send_byte(color[i*8 +: 8], i == 0);
        end
    endtask

    task automatic strobe_while_busy(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $urandom();
            @(negedge clk);
            assert (!ready) else fail_run("A stray byte was strobed outside a running fill");
            data_in    = (i == 0) ? panel_pkg::OP_FILL_PANEL : rnd[7:0];
            data_valid = 1'b1;
            @(negedge clk);
            data_valid = 1'b0;
        end
    endtask

    task automatic wait_for_done();
        @(negedge clk);
        while (!done) @(negedge clk);
        @(negedge clk);
        fill_pending = 1'b0;
    endtask

    task automatic expect_done_count(input int expected);
        assert (done_count == expected)
            else fail_run($sformatf("CHECK FAILED done pulse count: got 0x%0h expected 0x%0h",
                done_count, expected));
    endtask

    // One read per cycle with data one cycle behind the address
    task automatic check_frame();
        panel_pkg::byte_t expected;
        int               r;
        int               c;
        @(negedge clk);
        read_row    = '0;
        read_column = '0;
        for (int idx = 0; idx < PANEL_BYTES; idx++) begin
            @(negedge clk);
            r        = idx / COLUMNS;
            c        = idx % COLUMNS;
            expected = pixel_bytes[c % BYTES_PER_PIXEL];    // Byte n of a pixel is the nth sent
            assert (read_data == expected)
                else fail_run($sformatf(
                    "CHECK FAILED read_data row %0d column %0d: got 0x%02h expected 0x%02h",
                    r, c, read_data, expected));
            read_row    = panel_pkg::row_t'((idx + 1) / COLUMNS);
            read_column = panel_pkg::column_t'((idx + 1) % COLUMNS);
        end
    endtask

    initial begin
        logic [31:0]      rnd;
        panel_pkg::byte_t junk_opcode;
        rnd         = $urandom(RANDOM_SEED);
        data_in     = '0;
        data_valid  = 1'b0;
        read_row    = '0;
        read_column = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        color_a = random_color();
        start_fill(color_a);
        wait_for_done();
        expect_done_count(1);
        check_frame();

        color_b = random_color();
        while (color_b == color_a) color_b = random_color();
        start_fill(color_b);
        strobe_while_busy(6);    // Ignored, buffer must end up all color_b
        wait_for_done();
        expect_done_count(2);
        check_frame();

        junk_opcode = 8'h01;
        while (junk_opcode == panel_pkg::OP_FILL_PANEL) begin
            rnd         = $urandom();
            junk_opcode = rnd[7:0];
        end
        send_byte(junk_opcode, 1'b0);
        repeat (8) @(negedge clk);
        expect_done_count(2);
        color_c = random_color();
        start_fill(color_c);
        wait_for_done();
        expect_done_count(3);
        check_frame();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: hdl/panel_cmd_top.sv
`timescale 1ns/1ns

module panel_cmd_top #(
    parameter int PIXEL_WIDTH     = 16,
    parameter int PIXEL_HEIGHT    = 8,
    parameter int BYTES_PER_PIXEL = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  panel_pkg::byte_t   data_in,
    input  logic               data_valid,
    input  panel_pkg::row_t    read_row,
    input  panel_pkg::column_t read_column,
    output logic               ready,
    output logic               done,
    output panel_pkg::byte_t   read_data
);

    panel_pkg::byte_t             fill_data;
    logic                         fill_enable;
    logic                         fill_ready;
    logic                         engine_start;
    logic                         engine_clear;
    logic                         engine_done;
    logic [BYTES_PER_PIXEL*8-1:0] engine_color;
    panel_pkg::row_t              row;
    panel_pkg::column_t           column;
    panel_pkg::byte_t             wdata;
    logic                         write_enable;

    command_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .fill_ready  (fill_ready),
        .fill_done   (done),
        .fill_data   (fill_data),
        .fill_enable (fill_enable),
        .ready       (ready)
    );

    cmd_fill_panel #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_fill (
        .clk            (clk),
        .reset          (reset),
        .data_in        (fill_data),
        .enable         (fill_enable),
        .engine_done    (engine_done),
        .engine_start   (engine_start),
        .engine_clear   (engine_clear),
        .engine_color   (engine_color),
        .ready_for_data (fill_ready),
        .done           (done)
    );

    fill_area_engine #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_engine (
        .clk          (clk),
        .reset        (reset),
        .start        (engine_start),
        .clear        (engine_clear),
        .color        (engine_color),
        .row          (row),
        .column       (column),
        .wdata        (wdata),
        .write_enable (write_enable),
        .done         (engine_done)
    );

    frame_buffer #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_buffer (
        .clk          (clk),
        .row          (row),
        .column       (column),
        .wdata        (wdata),
        .write_enable (write_enable),
        .read_row     (read_row),
        .read_column  (read_column),
        .read_data    (read_data)
    );

endmodule

// File: hdl/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer #(
    parameter int PIXEL_WIDTH     = 16,
    parameter int PIXEL_HEIGHT    = 8,
    parameter int BYTES_PER_PIXEL = 2
) (
    input  logic               clk,
    input  panel_pkg::row_t    row,
    input  panel_pkg::column_t column,
    input  panel_pkg::byte_t   wdata,
    input  logic               write_enable,
    input  panel_pkg::row_t    read_row,
    input  panel_pkg::column_t read_column,
    output panel_pkg::byte_t   read_data
);

    localparam int COLUMNS = PIXEL_WIDTH * BYTES_PER_PIXEL;

    panel_pkg::byte_t mem [PIXEL_HEIGHT][COLUMNS];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[row][column] <= wdata;
        end
    end

    // One cycle read latency for the scanner side
    always_ff @(posedge clk) begin
        read_data <= mem[read_row][read_column];
    end

endmodule

// File: hdl/fill_area_engine.sv
`timescale 1ns/1ns

module fill_area_engine #(
    parameter int PIXEL_WIDTH     = 16,
    parameter int PIXEL_HEIGHT    = 8,
    parameter int BYTES_PER_PIXEL = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         clear,
    input  logic [BYTES_PER_PIXEL*8-1:0] color,
    output panel_pkg::row_t              row,
    output panel_pkg::column_t           column,
    output panel_pkg::byte_t             wdata,
    output logic                         write_enable,
    output logic                         done
);

    localparam int COLUMNS = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam panel_pkg::row_t    LAST_ROW    = panel_pkg::row_t'(PIXEL_HEIGHT - 1);
    localparam panel_pkg::column_t LAST_COLUMN = panel_pkg::column_t'(COLUMNS - 1);

    typedef enum logic [1:0] {
        IDLE,
        WRITING,
        FINISHED
    } engine_state_e;

    engine_state_e state;
    int            byte_select;

    assign write_enable = (state == WRITING) && start;

    // Byte 0 of a pixel is the most significant colour byte
    always_comb begin
        byte_select = BYTES_PER_PIXEL - 1 - (int'(column) % BYTES_PER_PIXEL);
        wdata       = color[byte_select*8 +: 8];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            row    <= '0;
            column <= '0;
            done   <= 1'b0;
        end else if (clear) begin
            state  <= IDLE;
            row    <= '0;
            column <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= WRITING;
                        row    <= '0;
                        column <= '0;
                    end
                end
                WRITING: begin
                    if (start) begin
                        if (column == LAST_COLUMN) begin
                            column <= '0;
                            if (row == LAST_ROW) begin
                                state <= FINISHED;
                                done  <= 1'b1;
                            end else begin
                                row <= row + panel_pkg::row_t'(1);
                            end
                        end else begin
                            column <= column + panel_pkg::column_t'(1);
                        end
                    end
                end
                FINISHED: state <= FINISHED;    // Held until clear
                default:  state <= IDLE;
            endcase
        end
    end

    // Start stays high until the last byte is written
    a_start_held_to_end: assert property (
        @(posedge clk) disable iff (reset)
        $fell(start) |-> state == FINISHED
    );

endmodule

// File: hdl/cmd_fill_panel.sv
`timescale 1ns/1ns

module cmd_fill_panel #(
    parameter int BYTES_PER_PIXEL = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  panel_pkg::byte_t             data_in,
    input  logic                         enable,
    input  logic                         engine_done,
    output logic                         engine_start,
    output logic                         engine_clear,
    output logic [BYTES_PER_PIXEL*8-1:0] engine_color,
    output logic                         ready_for_data,
    output logic                         done
);

    localparam int COUNT_W = (BYTES_PER_PIXEL > 1) ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(BYTES_PER_PIXEL - 1);

    panel_pkg::fill_state_e state;
    logic [COUNT_W-1:0]     bytes_remaining;
    logic                   capture;

    assign capture = enable && (state == panel_pkg::COLOR_CAPTURE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= panel_pkg::COLOR_CAPTURE;
            bytes_remaining <= LAST_COUNT;
            engine_start    <= 1'b0;
            engine_clear    <= 1'b0;
            ready_for_data  <= 1'b1;
            done            <= 1'b0;
        end else begin
            case (state)
                panel_pkg::COLOR_CAPTURE: begin
                    if (enable) begin
                        if (bytes_remaining == '0) begin
                            state          <= panel_pkg::START;
                            ready_for_data <= 1'b0;    // Last colour byte taken
                        end else begin
                            bytes_remaining <= bytes_remaining - COUNT_W'(1);
                        end
                    end
                end
                panel_pkg::START: begin
                    engine_start <= 1'b1;
                    state        <= panel_pkg::RUNNING;
                end
                panel_pkg::RUNNING: begin
                    if (engine_done) begin
                        engine_start <= 1'b0;
                        engine_clear <= 1'b1;    // Send engine back to idle
                        state        <= panel_pkg::PREDONE;
                    end
                end
                panel_pkg::PREDONE: begin
                    engine_clear <= 1'b0;
                    done         <= 1'b1;
                    state        <= panel_pkg::DONE;
                end
                panel_pkg::DONE: begin
                    done            <= 1'b0;
                    ready_for_data  <= 1'b1;
                    bytes_remaining <= LAST_COUNT;
                    state           <= panel_pkg::COLOR_CAPTURE;
                end
                default: state <= panel_pkg::COLOR_CAPTURE;
            endcase
        end
    end

    // Colour bytes arrive most significant first
    always_ff @(posedge clk) begin
        if (capture) begin
            engine_color[int'(bytes_remaining)*8 +: 8] <= data_in;
        end else if (state == panel_pkg::DONE) begin
            engine_color <= '0;
        end
    end

    // Engine may only finish a fill that is running
    a_engine_done_while_running: assert property (
        @(posedge clk) disable iff (reset)
        engine_done |-> state == panel_pkg::RUNNING
    );

endmodule

// File: hdl/command_decoder.sv
`timescale 1ns/1ns

module command_decoder (
    input  logic             clk,
    input  logic             reset,
    input  panel_pkg::byte_t data_in,
    input  logic             data_valid,
    input  logic             fill_ready,
    input  logic             fill_done,
    output panel_pkg::byte_t fill_data,
    output logic             fill_enable,
    output logic             ready
);

    typedef enum logic {
        WAIT_OPCODE,
        ROUTE_PAYLOAD
    } decode_state_e;

    decode_state_e state;
    logic          accepted;

    assign accepted    = data_valid && fill_ready;    // Strobes during a fill are dropped
    assign ready       = fill_ready;
    assign fill_data   = data_in;
    assign fill_enable = accepted && (state == ROUTE_PAYLOAD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= WAIT_OPCODE;
        end else begin
            case (state)
                WAIT_OPCODE: begin
                    // Unknown opcodes leave us here
                    if (accepted && data_in == panel_pkg::OP_FILL_PANEL) begin
                        state <= ROUTE_PAYLOAD;
                    end
                end
                ROUTE_PAYLOAD: begin
                    if (fill_done) begin
                        state <= WAIT_OPCODE;
                    end
                end
                default: state <= WAIT_OPCODE;
            endcase
        end
    end

    // Fill command is only busy while its payload is being routed
    a_busy_while_routing: assert property (
        @(posedge clk) disable iff (reset)
        !fill_ready |-> state == ROUTE_PAYLOAD
    );

endmodule

// File: hdl/panel_pkg.sv
package panel_pkg;

    typedef logic [7:0] byte_t;      // One stream byte or one buffer byte
    typedef logic [2:0] row_t;       // Panel height up to 8
    typedef logic [4:0] column_t;    // 16 pixels of 2 bytes

    // First byte of every command
    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'h01,
        OP_UNKNOWN    = 8'hff
    } opcode_e;

    // Fill command sequence
    typedef enum logic [2:0] {
        COLOR_CAPTURE,
        START,
        RUNNING,
        PREDONE,
        DONE
    } fill_state_e;

endpackage
